// ==== src/noc_pkg.sv ====
/*
 * Shared widths, vector typedefs, the mesh direction enum and the
 * request, flit and slave request structs of the group network wrapper
 */
package noc_pkg;

  parameter int unsigned NumTiles      = 4;
  parameter int unsigned TileIdxWidth  = 2;
  parameter int unsigned BankAddrWidth = 10;
  parameter int unsigned CoordWidth    = 2;
  parameter int unsigned NumMeshDirs   = 4; // North, East, South, West

  typedef logic [CoordWidth-1:0]                 coord_t;
  typedef logic [2*CoordWidth-1:0]               group_id_t; // {Y, X}
  typedef logic [TileIdxWidth-1:0]               tile_id_t;
  typedef logic [BankAddrWidth-1:0]              bank_addr_t;
  typedef logic [TileIdxWidth+BankAddrWidth-1:0] tgt_addr_t; // {tile, bank_addr}
  typedef logic [31:0]                           data_t;
  typedef logic [3:0]                            be_t;
  typedef logic [2:0]                            core_id_t;

  // Mesh directions first so they index mesh_valid_o directly
  typedef enum logic [2:0] {
    DirNorth = 3'd0,
    DirEast  = 3'd1,
    DirSouth = 3'd2,
    DirWest  = 3'd3,
    DirLocal = 3'd4
  } dir_e;

  typedef struct packed {
    group_id_t tgt_group;
    tgt_addr_t tgt_addr;
    tile_id_t  src_tile;
    core_id_t  core_id;
    logic      wen;
    be_t       be;
    data_t     data;
  } master_req_t;

  typedef struct packed {
    group_id_t src_id;   // Route back for the response
    group_id_t dst_id;   // XY routing target
    tile_id_t  src_tile;
    tgt_addr_t tgt_addr;
    core_id_t  core_id;
  } flit_hdr_t;

  typedef struct packed {
    logic  wen;
    be_t   be;
    data_t data;
  } flit_payload_t;

  typedef struct packed {
    flit_hdr_t     hdr;
    flit_payload_t payload;
  } flit_t;

  typedef struct packed {
    bank_addr_t tgt_addr; // Tile index already stripped
    tile_id_t   ini_tile;
    group_id_t  src_group;
    core_id_t   core_id;
    logic       wen;
    be_t        be;
    data_t      data;
  } slave_req_t;

endpackage

// ==== src/req_to_flit.sv ====
/*
 * Registered remap of a local master request into a network flit
 */
`timescale 1ns/10ps

module req_to_flit (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  noc_pkg::group_id_t  group_id_i,
  input  noc_pkg::master_req_t mreq_i,
  input  logic                mreq_valid_i,
  output logic                mreq_ready_o,
  output noc_pkg::flit_t      flit_o,
  output logic                flit_valid_o,
  input  logic                flit_ready_i
);

  import noc_pkg::*;

  flit_t flit_d;
  flit_t flit_q;
  logic  valid_q;

  // Header and payload of the outgoing flit
  always_comb begin
    flit_d.hdr.src_id       = group_id_i;       // Own group, for the response
    flit_d.hdr.dst_id       = mreq_i.tgt_group;
    flit_d.hdr.src_tile     = mreq_i.src_tile;
    flit_d.hdr.tgt_addr     = mreq_i.tgt_addr;
    flit_d.hdr.core_id      = mreq_i.core_id;
    flit_d.payload.wen      = mreq_i.wen;
    flit_d.payload.be       = mreq_i.be;
    flit_d.payload.data     = mreq_i.data;
  end

  // Free when empty or when the held flit leaves this cycle
  assign mreq_ready_o = !valid_q || flit_ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (mreq_ready_o) begin
      valid_q <= mreq_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (mreq_valid_i && mreq_ready_o) begin
      flit_q <= flit_d;
    end
  end

  assign flit_o       = flit_q;
  assign flit_valid_o = valid_q;

endmodule

// ==== src/flit_fifo.sv ====
/*
 * Channel FIFO for flits, circular buffer with read and write pointers
 */
`timescale 1ns/10ps

module flit_fifo #(
  parameter int unsigned Depth = 2
) (
  input  logic           clk_i,
  input  logic           rst_n_i,
  input  noc_pkg::flit_t flit_i,
  input  logic           valid_i,
  output logic           ready_o,
  output noc_pkg::flit_t flit_o,
  output logic           valid_o,
  input  logic           ready_i
);

  import noc_pkg::*;

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntWidth = $clog2(Depth + 1);

  flit_t                mem_q [Depth];
  logic  [PtrWidth-1:0] wr_ptr_q;
  logic  [PtrWidth-1:0] rd_ptr_q;
  logic  [CntWidth-1:0] count_q;
  logic                 push;
  logic                 pop;

  assign ready_o = (count_q != CntWidth'(Depth)); // Not full
  assign valid_o = (count_q != '0);
  assign flit_o  = mem_q[rd_ptr_q];

  assign push = valid_i && ready_o;
  assign pop  = valid_o && ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) count_q <= count_q + 1'b1;
      else if (pop && !push) count_q <= count_q - 1'b1;
    end
  end

  // Flit storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= flit_i;
    end
  end

endmodule

// ==== src/xy_route_stage.sv ====
/*
 * Registered XY dimension-order route decision
 */
`timescale 1ns/10ps

module xy_route_stage (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  noc_pkg::group_id_t group_id_i,
  input  noc_pkg::flit_t     flit_i,
  input  logic               valid_i,
  output logic               ready_o,
  output noc_pkg::flit_t     flit_o,
  output noc_pkg::dir_e      dir_o,
  output logic               valid_o,
  input  logic               ready_i
);

  import noc_pkg::*;

  coord_t own_x;
  coord_t own_y;
  coord_t dst_x;
  coord_t dst_y;
  dir_e   dir_d;
  dir_e   dir_q;
  flit_t  flit_q;
  logic   valid_q;

  assign own_x = group_id_i[CoordWidth-1:0];
  assign own_y = group_id_i[2*CoordWidth-1:CoordWidth];
  assign dst_x = flit_i.hdr.dst_id[CoordWidth-1:0];
  assign dst_y = flit_i.hdr.dst_id[2*CoordWidth-1:CoordWidth];

  // X first, then Y
  always_comb begin
    if (dst_x > own_x)      dir_d = DirEast;
    else if (dst_x < own_x) dir_d = DirWest;
    else if (dst_y > own_y) dir_d = DirNorth;
    else if (dst_y < own_y) dir_d = DirSouth;
    else                    dir_d = DirLocal;
  end

  assign ready_o = !valid_q || ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  // Flit and direction move together
  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      flit_q <= flit_i;
      dir_q  <= dir_d;
    end
  end

  assign flit_o  = flit_q;
  assign dir_o   = dir_q;
  assign valid_o = valid_q;

endmodule

// ==== src/port_steer.sv ====
/*
 * Steers a routed flit to one mesh port or to a local tile,
 * building the slave request for the local case
 */
`timescale 1ns/10ps

module port_steer (
  input  noc_pkg::flit_t                        flit_i,
  input  noc_pkg::dir_e                         dir_i,
  input  logic                                  valid_i,
  output logic                                  ready_o,
  output noc_pkg::flit_t                        mesh_flit_o,
  output logic [noc_pkg::NumMeshDirs-1:0]       mesh_valid_o,
  input  logic [noc_pkg::NumMeshDirs-1:0]       mesh_ready_i,
  output noc_pkg::slave_req_t                   slave_req_o,
  output logic [noc_pkg::NumTiles-1:0]          slave_valid_o,
  input  logic [noc_pkg::NumTiles-1:0]          slave_ready_i
);

  import noc_pkg::*;

  tile_id_t tile_sel;
  logic     is_local;

  // Tile index sits above the bank address
  assign tile_sel = flit_i.hdr.tgt_addr[BankAddrWidth +: TileIdxWidth];
  assign is_local = (dir_i == DirLocal);

  assign mesh_flit_o = flit_i; // Shared bus, valid picks the port

  always_comb begin
    slave_req_o.tgt_addr  = flit_i.hdr.tgt_addr[BankAddrWidth-1:0];
    slave_req_o.ini_tile  = flit_i.hdr.src_tile;
    slave_req_o.src_group = flit_i.hdr.src_id;
    slave_req_o.core_id   = flit_i.hdr.core_id;
    slave_req_o.wen       = flit_i.payload.wen;
    slave_req_o.be        = flit_i.payload.be;
    slave_req_o.data      = flit_i.payload.data;
  end

  always_comb begin
    mesh_valid_o  = '0;
    slave_valid_o = '0;
    if (is_local) begin
      slave_valid_o[tile_sel] = valid_i;
      ready_o                 = slave_ready_i[tile_sel];
    end else begin
      mesh_valid_o[dir_i[1:0]] = valid_i; // North..West map to 0..3
      ready_o                  = mesh_ready_i[dir_i[1:0]];
    end
  end

endmodule

// ==== src/group_noc_top.sv ====
/*
 * Request path of the group network wrapper: remap, channel FIFO,
 * XY route register and output steering
 */
`timescale 1ns/10ps

module group_noc_top #(
  parameter int unsigned FifoDepth = 2
) (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  noc_pkg::group_id_t              group_id_i,
  input  noc_pkg::master_req_t            mreq_i,
  input  logic                            mreq_valid_i,
  output logic                            mreq_ready_o,
  output noc_pkg::flit_t                  mesh_flit_o,
  output logic [noc_pkg::NumMeshDirs-1:0] mesh_valid_o,
  input  logic [noc_pkg::NumMeshDirs-1:0] mesh_ready_i,
  output noc_pkg::slave_req_t             slave_req_o,
  output logic [noc_pkg::NumTiles-1:0]    slave_valid_o,
  input  logic [noc_pkg::NumTiles-1:0]    slave_ready_i
);

  import noc_pkg::*;

  flit_t remap_flit;   // Stage 1 to FIFO
  logic  remap_valid;
  logic  remap_ready;
  flit_t fifo_flit;    // FIFO to route stage
  logic  fifo_valid;
  logic  fifo_ready;
  flit_t route_flit;   // Route stage to steering
  dir_e  route_dir;
  logic  route_valid;
  logic  route_ready;

  req_to_flit u_req_to_flit (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .group_id_i   (group_id_i),
    .mreq_i       (mreq_i),
    .mreq_valid_i (mreq_valid_i),
    .mreq_ready_o (mreq_ready_o),
    .flit_o       (remap_flit),
    .flit_valid_o (remap_valid),
    .flit_ready_i (remap_ready)
  );

  flit_fifo #(
    .Depth (FifoDepth)
  ) u_flit_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .flit_i  (remap_flit),
    .valid_i (remap_valid),
    .ready_o (remap_ready),
    .flit_o  (fifo_flit),
    .valid_o (fifo_valid),
    .ready_i (fifo_ready)
  );

  xy_route_stage u_xy_route (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .group_id_i (group_id_i),
    .flit_i     (fifo_flit),
    .valid_i    (fifo_valid),
    .ready_o    (fifo_ready),
    .flit_o     (route_flit),
    .dir_o      (route_dir),
    .valid_o    (route_valid),
    .ready_i    (route_ready)
  );

  port_steer u_port_steer (
    .flit_i        (route_flit),
    .dir_i         (route_dir),
    .valid_i       (route_valid),
    .ready_o       (route_ready),
    .mesh_flit_o   (mesh_flit_o),
    .mesh_valid_o  (mesh_valid_o),
    .mesh_ready_i  (mesh_ready_i),
    .slave_req_o   (slave_req_o),
    .slave_valid_o (slave_valid_o),
    .slave_ready_i (slave_ready_i)
  );

endmodule

// ==== verif/noc_chk.sv ====
/*
 * Handshake assertions on the request path top level, bound into it
 */
`timescale 1ns/10ps

module noc_chk (
  input logic                            clk_i,
  input logic                            rst_n_i,
  input noc_pkg::master_req_t            mreq_i,
  input logic                            mreq_valid_i,
  input logic                            mreq_ready_o,
  input noc_pkg::flit_t                  mesh_flit_o,
  input logic [noc_pkg::NumMeshDirs-1:0] mesh_valid_o,
  input logic [noc_pkg::NumMeshDirs-1:0] mesh_ready_i,
  input noc_pkg::slave_req_t             slave_req_o,
  input logic [noc_pkg::NumTiles-1:0]    slave_valid_o,
  input logic [noc_pkg::NumTiles-1:0]    slave_ready_i
);

  logic mesh_stall;
  logic slave_stall;

  assign mesh_stall  = |(mesh_valid_o & ~mesh_ready_i);   // Offered, not taken
  assign slave_stall = |(slave_valid_o & ~slave_ready_i);

  mreq_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mreq_valid_i && !mreq_ready_o |=> mreq_valid_i && $stable(mreq_i))
    else $error("Master request dropped or changed while stalled");

  mesh_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mesh_stall |=> $stable(mesh_valid_o) && $stable(mesh_flit_o))
    else $error("Mesh flit dropped or changed while stalled");

  slave_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    slave_stall |=> $stable(slave_valid_o) && $stable(slave_req_o))
    else $error("Slave request dropped or changed while stalled");

  one_valid_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0({mesh_valid_o, slave_valid_o}))
    else $error("More than one output valid at once");

  // Valids clear one edge into reset
  reset_idle_a: assert property (@(posedge clk_i)
    !rst_n_i |=> (mesh_valid_o == '0) && (slave_valid_o == '0))
    else $error("Output valid high during reset");

endmodule

bind group_noc_top noc_chk u_noc_chk (
  .clk_i         (clk_i),
  .rst_n_i       (rst_n_i),
  .mreq_i        (mreq_i),
  .mreq_valid_i  (mreq_valid_i),
  .mreq_ready_o  (mreq_ready_o),
  .mesh_flit_o   (mesh_flit_o),
  .mesh_valid_o  (mesh_valid_o),
  .mesh_ready_i  (mesh_ready_i),
  .slave_req_o   (slave_req_o),
  .slave_valid_o (slave_valid_o),
  .slave_ready_i (slave_ready_i)
);

// ==== verif/tb_top.sv ====
/*
 * Testbench for the group network request path: clock, reset, xorshift
 * stimulus, reference queue, compare tasks and closing summary
 */
`timescale 1ns/10ps

module tb_top;

  import noc_pkg::*;

  localparam int unsigned NumIsolated = 20;
  localparam int unsigned NumRandom   = 300;
  localparam int unsigned Latency     = 3;   // Input transfer to output valid

  typedef struct packed {
    dir_e        dir;
    tile_id_t    tile;
    flit_t       flit;
    slave_req_t  sreq;
    logic [31:0] cycle;     // Cycle of the input transfer
    logic        check_lat;
  } expect_t;

  logic                   clk_i;
  logic                   rst_n_i;
  group_id_t              group_id_i;
  master_req_t            mreq_i;
  logic                   mreq_valid_i;
  logic                   mreq_ready_o;
  flit_t                  mesh_flit_o;
  logic [NumMeshDirs-1:0] mesh_valid_o;
  logic [NumMeshDirs-1:0] mesh_ready_i;
  slave_req_t             slave_req_o;
  logic [NumTiles-1:0]    slave_valid_o;
  logic [NumTiles-1:0]    slave_ready_i;

  expect_t     exp_q[$];
  logic [31:0] rng_state;
  logic [31:0] cycle_cnt;
  int unsigned value_errs;
  int unsigned timeout_errs;
  int unsigned order_errs;
  int unsigned sent_cnt;
  int unsigned recv_cnt;
  int unsigned send_limit;
  int unsigned idle_left;
  logic        isolated_mode;  // One request in flight, readies high
  logic        req_taken;

  group_noc_top #(
    .FifoDepth (2)
  ) u_dut (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .group_id_i    (group_id_i),
    .mreq_i        (mreq_i),
    .mreq_valid_i  (mreq_valid_i),
    .mreq_ready_o  (mreq_ready_o),
    .mesh_flit_o   (mesh_flit_o),
    .mesh_valid_o  (mesh_valid_o),
    .mesh_ready_i  (mesh_ready_i),
    .slave_req_o   (slave_req_o),
    .slave_valid_o (slave_valid_o),
    .slave_ready_i (slave_ready_i)
  );

  always #5 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // X first, then Y
  function automatic dir_e expected_dir(input group_id_t own, input group_id_t dst);
    coord_t own_x;
    coord_t own_y;
    own_x = own[1:0];
    own_y = own[3:2];
    if (dst[1:0] > own_x) return DirEast;
    if (dst[1:0] < own_x) return DirWest;
    if (dst[3:2] > own_y) return DirNorth;
    if (dst[3:2] < own_y) return DirSouth;
    return DirLocal;
  endfunction

  function automatic expect_t build_expect(input master_req_t req, input logic [31:0] cyc,
                                           input logic lat);
    expect_t e;
    e.dir               = expected_dir(group_id_i, req.tgt_group);
    e.tile              = req.tgt_addr[11:10];
    e.flit.hdr.src_id   = group_id_i;
    e.flit.hdr.dst_id   = req.tgt_group;
    e.flit.hdr.src_tile = req.src_tile;
    e.flit.hdr.tgt_addr = req.tgt_addr;
    e.flit.hdr.core_id  = req.core_id;
    e.flit.payload.wen  = req.wen;
    e.flit.payload.be   = req.be;
    e.flit.payload.data = req.data;
    e.sreq.tgt_addr     = req.tgt_addr[9:0];  // Tile bits stripped
    e.sreq.ini_tile     = req.src_tile;
    e.sreq.src_group    = group_id_i;
    e.sreq.core_id      = req.core_id;
    e.sreq.wen          = req.wen;
    e.sreq.be           = req.be;
    e.sreq.data         = req.data;
    e.cycle             = cyc;
    e.check_lat         = lat;
    return e;
  endfunction

  function automatic master_req_t random_request();
    master_req_t req;
    logic [31:0] r0;
    r0 = next_rand();
    if (r0[0]) req.tgt_group = group_id_i;  // Roughly half stay local
    else req.tgt_group = r0[4:1];
    req.tgt_addr = r0[16:5];
    req.src_tile = r0[18:17];
    req.core_id  = r0[21:19];
    req.wen      = r0[22];
    req.be       = r0[26:23];
    req.data     = next_rand();
    return req;
  endfunction

  task automatic compare_flit(input flit_t exp, input flit_t act);
    if (act !== exp) begin
      value_errs++;
      $display("ERR mesh_flit_o expected 0x%h actual 0x%h at %0t", exp, act, $time);
    end
  endtask

  task automatic compare_slave(input slave_req_t exp, input slave_req_t act);
    if (act !== exp) begin
      value_errs++;
      $display("ERR slave_req_o expected 0x%h actual 0x%h at %0t", exp, act, $time);
    end
  endtask

  task automatic compare_dir(input dir_e exp, input dir_e act);
    if (act !== exp) begin
      value_errs++;
      $display("ERR output direction expected 0x%h actual 0x%h at %0t", exp, act, $time);
    end
  endtask

  task automatic compare_tile(input tile_id_t exp, input tile_id_t act);
    if (act !== exp) begin
      value_errs++;
      $display("ERR slave_valid_o tile expected 0x%h actual 0x%h at %0t", exp, act, $time);
    end
  endtask

  task automatic compare_bits(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
      value_errs++;
      $display("ERR %s expected 0x%h actual 0x%h at %0t", name, exp, act, $time);
    end
  endtask

  task automatic drive_inputs();
    logic [31:0] r;
    r = next_rand();
    if (isolated_mode) begin
      mesh_ready_i  = '1;
      slave_ready_i = '1;
    end else begin
      mesh_ready_i  = r[3:0] | r[7:4];    // About three quarters ready
      slave_ready_i = r[11:8] | r[15:12];
    end
    if (req_taken) begin
      mreq_valid_i = 1'b0;
      req_taken    = 1'b0;
    end
    if (!mreq_valid_i && sent_cnt < send_limit && (!isolated_mode || exp_q.size() == 0)) begin
      if (idle_left != 0) begin
        idle_left--;
      end else begin
        mreq_i       = random_request();
        mreq_valid_i = 1'b1;
      end
    end
  endtask

  // Sees the handshakes that complete on the coming rising edge
  task automatic monitor_cycle();
    expect_t  e;
    dir_e     act_dir;
    tile_id_t act_tile;
    logic     fired;
    logic [31:0] r;
    fired    = 1'b0;
    act_dir  = DirLocal;
    act_tile = '0;
    for (int d = 0; d < NumMeshDirs; d++) begin
      if (mesh_valid_o[d] && mesh_ready_i[d]) begin
        fired   = 1'b1;
        act_dir = dir_e'(3'(d));
      end
    end
    for (int t = 0; t < NumTiles; t++) begin
      if (slave_valid_o[t] && slave_ready_i[t]) begin
        fired    = 1'b1;
        act_dir  = DirLocal;
        act_tile = tile_id_t'(t);
      end
    end
    if (fired) begin
      if (exp_q.size() == 0) begin
        order_errs++;
        $display("Output transfer at %0t with no request outstanding", $time);
      end else begin
        e = exp_q.pop_front();
        recv_cnt++;
        compare_dir(e.dir, act_dir);
        if (act_dir == DirLocal) begin
          compare_tile(e.tile, act_tile);
          compare_slave(e.sreq, slave_req_o);
        end else begin
          compare_flit(e.flit, mesh_flit_o);
        end
        if (e.check_lat && (cycle_cnt - e.cycle) != Latency) begin
          value_errs++;
          $display("ERR output latency expected 0x%h actual 0x%h", Latency, cycle_cnt - e.cycle);
        end
      end
    end
    if (mreq_valid_i && mreq_ready_o) begin
      exp_q.push_back(build_expect(mreq_i, cycle_cnt, isolated_mode));
      sent_cnt++;
      req_taken = 1'b1;
      r = next_rand();
      idle_left = isolated_mode ? 32'(r[1:0]) + 1 : 32'(r[1:0]);
    end
  endtask

  task automatic step_cycle();
    @(negedge clk_i);
    drive_inputs();
    #1;
    monitor_cycle();
    cycle_cnt++;
  endtask

  task automatic run_phase(input int unsigned count, input logic isolated);
    int unsigned waited;
    int unsigned limit;
    isolated_mode = isolated;
    send_limit    = sent_cnt + count;
    limit         = count * 20 + 100;
    waited        = 0;
    while ((sent_cnt < send_limit || exp_q.size() != 0) && waited < limit) begin
      step_cycle();
      waited++;
    end
    if (sent_cnt < send_limit || exp_q.size() != 0) begin
      timeout_errs++;
      $display("Timeout: %0d requests still outstanding after %0d cycles",
               exp_q.size(), waited);
    end
  endtask

  initial begin
    int unsigned total;
    clk_i         = 1'b0;
    rst_n_i       = 1'b0;
    group_id_i    = {2'd2, 2'd1};  // Y=2, X=1
    mreq_i        = '0;
    mreq_valid_i  = 1'b0;
    mesh_ready_i  = '1;
    slave_ready_i = '1;
    rng_state     = 32'd77056;
    cycle_cnt     = '0;
    value_errs    = 0;
    timeout_errs  = 0;
    order_errs    = 0;
    sent_cnt      = 0;
    recv_cnt      = 0;
    send_limit    = 0;
    idle_left     = 0;
    isolated_mode = 1'b1;
    req_taken     = 1'b0;
    repeat (8) @(negedge clk_i);
    rst_n_i = 1'b1;
    #1;
    compare_bits("mesh_valid_o", 8'h00, 8'(mesh_valid_o));
    compare_bits("slave_valid_o", 8'h00, 8'(slave_valid_o));
    compare_bits("mreq_ready_o", 8'h01, 8'(mreq_ready_o));
    run_phase(NumIsolated, 1'b1);
    run_phase(NumRandom, 1'b0);
    total = value_errs + timeout_errs + order_errs;
    $display("Summary: sent %0d, received %0d, value errors %0d, timeouts %0d, order errors %0d",
             sent_cnt, recv_cnt, value_errs, timeout_errs, order_errs);
    if (total == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
src/noc_pkg.sv
src/req_to_flit.sv
src/flit_fifo.sv
src/xy_route_stage.sv
src/port_steer.sv
src/group_noc_top.sv
verif/noc_chk.sv
verif/tb_top.sv

// ==== run.sh ====
#!/bin/sh
# Compiles the testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/10ps \
  --top-module tb_top -f tb.f --Mdir obj_dir -o tb_top_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/tb_top_sim)
sim_status=$?
printf '%s\n' "$sim_out"

if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Regression passed"; then
  exit 0
fi

echo "Pass line not found in simulation output"
exit 1
